// File: mbus_ice_tx.f
mbus_ice_pkg.sv
ice_frame_rx.sv
ice_char_fifo.sv
mbus_ice_driver_tx.sv
ice_acknak_gen.sv
mbus_ice_tx.sv
tb_mbus_ice_tx.sv

// File: Makefile
VERILATOR ?= verilator
TOP       := tb_mbus_ice_tx
FILELIST  := mbus_ice_tx.f
FLAGS     := --binary --timing --assert
LOG       := sim.log

.PHONY: all run lint clean

all: run

obj_dir/V$(TOP): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "ALL TESTS PASSED" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf obj_dir $(LOG)

// File: tb_mbus_ice_tx.sv
`timescale 1ns/1ps
`default_nettype none

module tb_mbus_ice_tx;
    import mbus_ice_pkg::*;

    localparam int num_frames = 7;  // junk frame included

    logic        clk = 1'b0;
    logic        reset;
    logic        in_valid;
    logic [7:0]  in_char;
    logic        out_valid;
    logic [7:0]  out_char;
    logic [31:0] mbus_txaddr;
    logic [31:0] mbus_txdata;
    logic        mbus_txreq;
    logic        mbus_txpend;
    logic        mbus_txack;
    logic        mbus_txsucc;
    logic        mbus_txfail;
    logic        mbus_txresp_ack;

    int seed = 32'hccd6;
    int errors = 0;

    // expected words and response bytes, filled by the host
    logic [31:0] addr_mem [64];
    logic [31:0] data_mem [64];
    logic        pend_mem [64];
    logic [7:0]  resp_mem [64];
    logic        result_mem [16];  // 1 means the bus reports a failure
    logic [5:0]  word_wr = '0;
    logic [5:0]  word_idx = '0;
    logic [5:0]  resp_wr = '0;
    logic [5:0]  resp_idx = '0;
    logic [3:0]  frame_wr = '0;
    logic [3:0]  frame_idx = '0;

    logic        req_q = 1'b0;
    logic        reset_q = 1'b0;
    logic        req_rise;
    logic [31:0] exp_addr;
    logic [31:0] exp_data;
    logic        exp_pend;
    logic [7:0]  exp_char;

    assign req_rise = mbus_txreq && !req_q;
    assign exp_addr = addr_mem[word_idx];
    assign exp_data = data_mem[word_idx];
    assign exp_pend = pend_mem[word_idx];
    assign exp_char = resp_mem[resp_idx];

    mbus_ice_tx u_mbus_ice_tx (
        .clk             (clk),
        .reset           (reset),
        .in_valid        (in_valid),
        .in_char         (in_char),
        .out_valid       (out_valid),
        .out_char        (out_char),
        .mbus_txaddr     (mbus_txaddr),
        .mbus_txdata     (mbus_txdata),
        .mbus_txreq      (mbus_txreq),
        .mbus_txpend     (mbus_txpend),
        .mbus_txack      (mbus_txack),
        .mbus_txsucc     (mbus_txsucc),
        .mbus_txfail     (mbus_txfail),
        .mbus_txresp_ack (mbus_txresp_ack)
    );

    always #2 clk = ~clk;

    always @(posedge clk) begin
        req_q   <= mbus_txreq;
        reset_q <= reset;
        if (out_valid) begin
            resp_idx <= resp_idx + 6'd1;
        end
    end

    a_addr: assert property (@(posedge clk) disable iff (reset)
        req_rise |-> mbus_txaddr == exp_addr)
        else begin
            errors++;
            $display("FAIL mbus_txaddr expected %h actual %h",
                     $sampled(exp_addr), $sampled(mbus_txaddr));
        end
    a_data: assert property (@(posedge clk) disable iff (reset)
        req_rise |-> mbus_txdata == exp_data)
        else begin
            errors++;
            $display("FAIL mbus_txdata expected %h actual %h",
                     $sampled(exp_data), $sampled(mbus_txdata));
        end
    a_pend: assert property (@(posedge clk) disable iff (reset)
        req_rise |-> mbus_txpend == exp_pend)
        else begin
            errors++;
            $display("FAIL mbus_txpend expected %h actual %h",
                     $sampled(exp_pend), $sampled(mbus_txpend));
        end
    a_req_expected: assert property (@(posedge clk) disable iff (reset)
        mbus_txreq |-> word_idx != word_wr)
        else begin
            errors++;
            $display("mbus request raised with no word pending from the host");
        end
    a_resp: assert property (@(posedge clk) disable iff (reset)
        out_valid |-> out_char == exp_char)
        else begin
            errors++;
            $display("FAIL out_char expected %h actual %h",
                     $sampled(exp_char), $sampled(out_char));
        end
    a_resp_expected: assert property (@(posedge clk) disable iff (reset)
        out_valid |-> resp_idx != resp_wr)
        else begin
            errors++;
            $display("response byte sent when none was expected");
        end
    a_resp_ack_hold: assert property (@(posedge clk) disable iff (reset)
        out_valid |-> mbus_txresp_ack)
        else begin
            errors++;
            $display("FAIL mbus_txresp_ack expected %h actual %h",
                     1'b1, $sampled(mbus_txresp_ack));
        end
    a_reset: assert property (@(posedge clk)
        reset_q |-> !mbus_txreq && !out_valid)
        else begin
            errors++;
            $display("mbus_txreq or out_valid high right after reset");
        end

    task automatic apply_reset();
        reset <= 1'b1;
        repeat (3) @(posedge clk);
        reset <= 1'b0;
        @(posedge clk);
    endtask

    task automatic send_byte(input logic [7:0] b);
        int gap;
        gap = $random(seed) & 3;  // host idles 0..3 cycles
        repeat (gap) @(posedge clk);
        in_valid <= 1'b1;
        in_char  <= b;
        @(posedge clk);
        in_valid <= 1'b0;
    endtask

    task automatic send_word(input logic [31:0] w);
        send_byte(w[31:24]);
        send_byte(w[23:16]);
        send_byte(w[15:8]);
        send_byte(w[7:0]);
    endtask

    // no 'b' anywhere, so the parser must stay quiet
    task automatic send_junk();
        send_byte(8'h63);
        send_byte(8'h05);
        send_byte(8'h08);
        send_word(32'h1111_1111);
        send_word(32'h1111_1111);
        repeat (20) @(posedge clk);
    endtask

    task automatic send_frame(input logic [7:0] id, input logic [31:0] addr,
                              input int nwords, input logic fail);
        logic [31:0] data;
        result_mem[frame_wr] = fail;
        frame_wr = frame_wr + 4'd1;
        resp_mem[resp_wr] = fail ? ice_resp_nak : ice_resp_ack;
        resp_mem[resp_wr + 6'd1] = id;
        resp_mem[resp_wr + 6'd2] = 8'h00;
        resp_wr = resp_wr + 6'd3;
        send_byte(ice_cmd_tx);
        send_byte(id);
        send_byte(8'(4 + 4 * nwords));
        send_word(addr);
        for (int w = 0; w < nwords; w++) begin
            data = $random(seed);
            addr_mem[word_wr] = addr;
            data_mem[word_wr] = data;
            pend_mem[word_wr] = (w != nwords - 1);  // last word has no pend
            word_wr = word_wr + 6'd1;
            send_word(data);
        end
        wait (resp_idx == resp_wr);
        @(posedge clk);
    endtask

    // reset hits while the request is up, so no response follows
    task automatic send_aborted_frame(input logic [7:0] id, input logic [31:0] addr);
        logic [31:0] data;
        data = $random(seed);
        result_mem[frame_wr] = 1'b0;
        frame_wr = frame_wr + 4'd1;
        addr_mem[word_wr] = addr;
        data_mem[word_wr] = data;
        pend_mem[word_wr] = 1'b0;
        word_wr = word_wr + 6'd1;
        send_byte(ice_cmd_tx);
        send_byte(id);
        send_byte(8'd8);
        send_word(addr);
        send_word(data);
        wait (mbus_txreq);
        @(posedge clk);
        apply_reset();
        wait (frame_idx == frame_wr);  // bus model finishes its sequence
        @(posedge clk);
    endtask

    // mbus target side
    initial begin : mbus_target
        int   delay;
        logic last_word;
        mbus_txack  = 1'b0;
        mbus_txsucc = 1'b0;
        mbus_txfail = 1'b0;
        forever begin
            @(posedge clk);
            if (mbus_txreq && !reset) begin
                last_word = !mbus_txpend;
                delay = $random(seed) & 7;
                repeat (delay) @(posedge clk);
                mbus_txack <= 1'b1;
                @(posedge clk);
                while (mbus_txreq) @(posedge clk);
                mbus_txack <= 1'b0;
                word_idx   <= word_idx + 6'd1;
                if (last_word) begin
                    delay = $random(seed) & 3;
                    repeat (delay + 1) @(posedge clk);
                    if (result_mem[frame_idx]) begin
                        mbus_txfail <= 1'b1;
                    end else begin
                        mbus_txsucc <= 1'b1;
                    end
                    @(posedge clk);
                    mbus_txfail <= 1'b0;
                    mbus_txsucc <= 1'b0;
                    frame_idx   <= frame_idx + 4'd1;
                end
            end
        end
    end

    initial begin : watchdog
        repeat (num_frames * 200) @(posedge clk);
        $display("timeout, run did not finish within %0d cycles", num_frames * 200);
        $display("SOME TESTS FAILED");
        $finish;
    end

    initial begin : main
        reset    = 1'b1;
        in_valid = 1'b0;
        in_char  = 8'h00;
        apply_reset();
        send_junk();
        send_frame(8'h11, 32'ha000_0010, 1, 1'b0);
        send_frame(8'h22, 32'h1234_5678, 3, 1'b0);
        send_frame(8'h33, 32'hdead_0001, 1, 1'b1);
        send_aborted_frame(8'h3c, 32'hbeef_0002);
        send_frame(8'h44, 32'h0f0f_a5a5, (ice_max_payload - 4) / 4, 1'b1);
        send_frame(8'h55, 32'h7654_3210, 2, 1'b0);
        repeat (20) @(posedge clk);
        assert (word_idx == word_wr) else begin
            errors++;
            $display("not every expected mbus word was requested");
        end
        assert (frame_idx == frame_wr) else begin
            errors++;
            $display("not every frame reached its bus result");
        end
        $display("checks done, %0d errors", errors);
        if (errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: mbus_ice_tx.sv
`timescale 1ns/1ps
`default_nettype none

module mbus_ice_tx (
    input  logic        clk,
    input  logic        reset,
    input  logic        in_valid,
    input  logic [7:0]  in_char,
    output logic        out_valid,
    output logic [7:0]  out_char,
    output logic [31:0] mbus_txaddr,
    output logic [31:0] mbus_txdata,
    output logic        mbus_txreq,
    output logic        mbus_txpend,
    input  logic        mbus_txack,
    input  logic        mbus_txsucc,
    input  logic        mbus_txfail,
    output logic        mbus_txresp_ack
);

    logic       fifo_wr;
    logic [7:0] fifo_wdata;
    logic       frame_valid;
    logic       char_pending;
    logic [7:0] event_id;
    logic       char_advance;
    logic       char_valid;
    logic [7:0] tx_char;
    logic       gen_ack;
    logic       gen_nak;
    logic       acknak_valid;

    ice_frame_rx u_frame_rx (
        .clk          (clk),
        .reset        (reset),
        .in_valid     (in_valid),
        .in_char      (in_char),
        .char_advance (char_advance),
        .fifo_wr      (fifo_wr),
        .fifo_wdata   (fifo_wdata),
        .frame_valid  (frame_valid),
        .char_pending (char_pending),
        .event_id     (event_id)
    );

    ice_char_fifo u_char_fifo (
        .clk       (clk),
        .reset     (reset),
        .wr        (fifo_wr),
        .wdata     (fifo_wdata),
        .rd        (char_advance),
        .rdata     (tx_char),
        .not_empty (char_valid)
    );

    mbus_ice_driver_tx u_driver_tx (
        .clk             (clk),
        .reset           (reset),
        .frame_valid     (frame_valid),
        .char_valid      (char_valid),
        .tx_char         (tx_char),
        .char_pending    (char_pending),
        .char_advance    (char_advance),
        .mbus_txaddr     (mbus_txaddr),
        .mbus_txdata     (mbus_txdata),
        .mbus_txreq      (mbus_txreq),
        .mbus_txpend     (mbus_txpend),
        .mbus_txack      (mbus_txack),
        .mbus_txfail     (mbus_txfail),
        .mbus_txsucc     (mbus_txsucc),
        .mbus_txresp_ack (mbus_txresp_ack),
        .gen_ack         (gen_ack),
        .gen_nak         (gen_nak),
        .acknak_valid    (acknak_valid)
    );

    ice_acknak_gen u_acknak_gen (
        .clk          (clk),
        .reset        (reset),
        .gen_ack      (gen_ack),
        .gen_nak      (gen_nak),
        .event_id     (event_id),
        .out_valid    (out_valid),
        .out_char     (out_char),
        .acknak_valid (acknak_valid)
    );

endmodule

`default_nettype wire

// File: ice_acknak_gen.sv
`timescale 1ns/1ps
`default_nettype none

module ice_acknak_gen (
    input  logic       clk,
    input  logic       reset,
    input  logic       gen_ack,
    input  logic       gen_nak,
    input  logic [7:0] event_id,
    output logic       out_valid,
    output logic [7:0] out_char,
    output logic       acknak_valid
);
    import mbus_ice_pkg::*;

    logic       busy;
    logic       is_nak;
    logic [1:0] cnt;  // byte index in the response

    always_ff @(posedge clk) begin
        if (reset) begin
            busy   <= 1'b0;
            is_nak <= 1'b0;
            cnt    <= 2'd0;
        end else if (gen_ack || gen_nak) begin
            busy   <= 1'b1;
            is_nak <= gen_nak;
            cnt    <= 2'd0;
        end else if (busy) begin
            cnt <= cnt + 2'd1;
            if (cnt == 2'd2) begin
                busy <= 1'b0;  // length byte was the last
            end
        end
    end

    assign out_valid    = busy;
    assign acknak_valid = busy;

    always_comb begin
        case (cnt)
            2'd0:    out_char = is_nak ? ice_resp_nak : ice_resp_ack;
            2'd1:    out_char = event_id;
            default: out_char = 8'h00;  // zero payload length
        endcase
    end

endmodule

`default_nettype wire

// File: mbus_ice_driver_tx.sv
`timescale 1ns/1ps
`default_nettype none

module mbus_ice_driver_tx (
    input  logic        clk,
    input  logic        reset,
    input  logic        frame_valid,
    input  logic        char_valid,
    input  logic [7:0]  tx_char,
    input  logic        char_pending,
    output logic        char_advance,
    output logic [31:0] mbus_txaddr,
    output logic [31:0] mbus_txdata,
    output logic        mbus_txreq,
    output logic        mbus_txpend,
    input  logic        mbus_txack,
    input  logic        mbus_txfail,
    input  logic        mbus_txsucc,
    output logic        mbus_txresp_ack,
    output logic        gen_ack,
    output logic        gen_nak,
    input  logic        acknak_valid
);

    localparam logic [3:0] st_tx_idle        = 4'd0;
    localparam logic [3:0] st_tx_shift_addr0 = 4'd1;
    localparam logic [3:0] st_tx_shift_addr1 = 4'd2;
    localparam logic [3:0] st_tx_shift_addr2 = 4'd3;
    localparam logic [3:0] st_tx_shift_addr3 = 4'd4;
    localparam logic [3:0] st_tx_shift_data0 = 4'd5;
    localparam logic [3:0] st_tx_shift_data1 = 4'd6;
    localparam logic [3:0] st_tx_shift_data2 = 4'd7;
    localparam logic [3:0] st_tx_shift_data3 = 4'd8;
    localparam logic [3:0] st_tx_wait        = 4'd9;
    localparam logic [3:0] st_tx_txreq       = 4'd10;
    localparam logic [3:0] st_tx_txack       = 4'd11;
    localparam logic [3:0] st_tx_txsucc      = 4'd12;
    localparam logic [3:0] st_tx_result      = 4'd13;

    logic [3:0] state;
    logic [3:0] next_state;
    logic       addr_shift;
    logic       data_shift;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= st_tx_idle;
        end else begin
            state <= next_state;
        end
    end

    // bytes arrive msb first
    always_ff @(posedge clk) begin
        if (addr_shift) begin
            mbus_txaddr <= {mbus_txaddr[23:0], tx_char};
        end
        if (data_shift) begin
            mbus_txdata <= {mbus_txdata[23:0], tx_char};
        end
    end

    assign char_advance = addr_shift | data_shift;

    always_comb begin
        next_state      = state;
        addr_shift      = 1'b0;
        data_shift      = 1'b0;
        mbus_txreq      = 1'b0;
        mbus_txpend     = 1'b0;
        mbus_txresp_ack = 1'b0;
        gen_ack         = 1'b0;
        gen_nak         = 1'b0;

        case (state)
            st_tx_idle: begin
                if (frame_valid) begin
                    next_state = st_tx_shift_addr0;
                end
            end
            st_tx_shift_addr0, st_tx_shift_addr1,
            st_tx_shift_addr2, st_tx_shift_addr3: begin
                addr_shift = char_valid;  // stall on empty fifo
                if (char_valid) begin
                    next_state = state + 4'd1;
                end
            end
            st_tx_shift_data0, st_tx_shift_data1,
            st_tx_shift_data2, st_tx_shift_data3: begin
                data_shift = char_valid;
                if (char_valid) begin
                    next_state = state + 4'd1;  // data3 falls into wait
                end
            end
            st_tx_wait: begin
                next_state = st_tx_txreq;
            end
            st_tx_txreq: begin
                mbus_txreq  = 1'b1;
                mbus_txpend = char_pending;  // more words follow
                if (mbus_txack) begin
                    next_state = st_tx_txack;
                end
            end
            st_tx_txack: begin
                if (!mbus_txack) begin
                    next_state = char_pending ? st_tx_shift_data0 : st_tx_txsucc;
                end
            end
            st_tx_txsucc: begin
                if (mbus_txsucc) begin
                    gen_ack    = 1'b1;
                    next_state = st_tx_result;
                end else if (mbus_txfail) begin
                    gen_nak    = 1'b1;
                    next_state = st_tx_result;
                end
            end
            st_tx_result: begin
                mbus_txresp_ack = 1'b1;
                // hold until the response frame is out
                if (!acknak_valid) begin
                    next_state = st_tx_idle;
                end
            end
            default: begin
                next_state = st_tx_idle;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: ice_char_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module ice_char_fifo (
    input  logic       clk,
    input  logic       reset,
    input  logic       wr,
    input  logic [7:0] wdata,
    input  logic       rd,
    output logic [7:0] rdata,
    output logic       not_empty
);
    import mbus_ice_pkg::*;

    logic [7:0]              mem [char_fifo_depth];
    logic [char_fifo_aw-1:0] rd_ptr;
    logic [char_fifo_aw-1:0] wr_ptr;
    logic [char_fifo_aw:0]   count;
    logic                    full;
    logic                    wr_en;
    logic                    rd_en;

    assign full      = (count == (char_fifo_aw + 1)'(char_fifo_depth));
    assign not_empty = (count != '0);
    assign rd_en     = rd && not_empty;
    assign wr_en     = wr && (!full || rd_en);  // pop frees a slot in the same cycle
    assign rdata     = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_ptr] <= wdata;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= wr_ptr + 1'b1;  // wraps at depth
            end
            if (rd_en) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            if (wr_en && !rd_en) begin
                count <= count + 1'b1;
            end else if (rd_en && !wr_en) begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// File: ice_frame_rx.sv
`timescale 1ns/1ps
`default_nettype none

module ice_frame_rx (
    input  logic       clk,
    input  logic       reset,
    input  logic       in_valid,
    input  logic [7:0] in_char,
    input  logic       char_advance,
    output logic       fifo_wr,
    output logic [7:0] fifo_wdata,
    output logic       frame_valid,
    output logic       char_pending,
    output logic [7:0] event_id
);
    import mbus_ice_pkg::*;

    localparam logic [1:0] st_cmd     = 2'd0;
    localparam logic [1:0] st_event   = 2'd1;
    localparam logic [1:0] st_len     = 2'd2;
    localparam logic [1:0] st_payload = 2'd3;

    logic [1:0]       state;
    logic [len_w-1:0] rx_left;     // payload bytes still to arrive
    logic [len_w-1:0] unconsumed;  // bytes the driver has not taken yet
    logic             len_ok;
    logic             len_take;

    // zero or oversized lengths drop the frame
    assign len_ok   = (len_w'(in_char) != '0) &&
                      (len_w'(in_char) <= len_w'(ice_max_payload));
    assign len_take = in_valid && (state == st_len) && len_ok;

    assign fifo_wr      = in_valid && (state == st_payload);
    assign fifo_wdata   = in_char;
    assign char_pending = (unconsumed != '0);

    always_ff @(posedge clk) begin
        if (reset) begin
            state   <= st_cmd;
            rx_left <= '0;
        end else if (in_valid) begin
            case (state)
                st_cmd: begin
                    if (in_char == ice_cmd_tx) begin
                        state <= st_event;  // anything else is ignored
                    end
                end
                st_event: begin
                    state <= st_len;
                end
                st_len: begin
                    rx_left <= len_w'(in_char);
                    state   <= len_ok ? st_payload : st_cmd;
                end
                default: begin
                    rx_left <= rx_left - 1'b1;
                    if (rx_left == len_w'(1)) begin
                        state <= st_cmd;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && (state == st_event)) begin
            event_id <= in_char;
        end
    end

    // frame stays valid until the driver pops the last byte
    always_ff @(posedge clk) begin
        if (reset) begin
            unconsumed  <= '0;
            frame_valid <= 1'b0;
        end else if (len_take) begin
            unconsumed  <= len_w'(in_char);
            frame_valid <= 1'b1;
        end else if (char_advance && (unconsumed != '0)) begin
            unconsumed <= unconsumed - 1'b1;
            if (unconsumed == len_w'(1)) begin
                frame_valid <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

// File: mbus_ice_pkg.sv
`default_nettype none

package mbus_ice_pkg;

    // ice command and response codes, ascii
    localparam logic [7:0] ice_cmd_tx   = 8'h62;  // 'b'
    localparam logic [7:0] ice_resp_ack = 8'h61;  // 'a'
    localparam logic [7:0] ice_resp_nak = 8'h6e;  // 'n'

    // address word plus up to six data words
    localparam int ice_max_payload = 28;

    // width of the length and byte counters
    localparam int len_w = 8;

    // char fifo between parser and driver
    localparam int char_fifo_depth = 32;
    localparam int char_fifo_aw    = 5;  // log2 of depth

endpackage

`default_nettype wire
